/* list.f */
common/cpu_bus_pkg.sv
common/cpu_isa_pkg.sv
design/bus_unit.sv
control/control.sv
design/datapath.sv
design/interrupt_unit.sv
design/cpu_top.sv
tests/tb_clock.sv
tests/cpu_assertions.sv
tests/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_top.sv */
`timescale 1ns/100ps

module tb_top;
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    localparam int prog_m_cycles = 19;
    localparam int watchdog_ns   = (prog_m_cycles + 40) * 32;

    logic      clk;
    logic      rst;
    logic      phi;
    addr_t     addr;
    data_t     dout;
    data_t     din;
    logic      rd;
    logic      wr;
    int_mask_t int_en;
    int_mask_t int_flags_in;
    int_mask_t int_flags_out;
    data_t     key_in;
    logic      done;

    data_t     mem [0:65535];
    int        cycle = 0;
    int        last_rd = 0;
    int        errors = 0;
    int        seed = 32'h1aea;
    int_mask_t flags;
    int_mask_t drop_seen = '0;
    addr_t     vec;

    tb_clock i_clock (.clk(clk), .rst(rst));

    cpu_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .phi           (phi),
        .addr          (addr),
        .dout          (dout),
        .din           (din),
        .rd            (rd),
        .wr            (wr),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .int_flags_out (int_flags_out),
        .key_in        (key_in),
        .done          (done)
    );

    bind cpu_top cpu_assertions i_assertions (.*);

    //////////////////////////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////////////////////////
    assign din = rd ? mem[addr] : 8'h00;

    always @(negedge clk) begin
        if (wr)
            mem[addr] <= dout;  // Middle of the wr pulse
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // Lines that int_flags_out has shown as serviced
    always @(posedge clk)
        drop_seen <= drop_seen | (int_flags_in & ~int_flags_out);

    task automatic load_program();
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'(i ^ (i >> 8));
        mem[16'h0000] = op_nop;
        mem[16'h0001] = op_nop;
        mem[16'h0002] = op_nop;
        mem[16'h0003] = op_ld_a_n;
        mem[16'h0004] = 8'h5a;
        mem[16'h0005] = op_ldh_n_a;
        mem[16'h0006] = 8'h42;
        mem[16'h0007] = op_jp_nn;
        mem[16'h0008] = 8'h00;
        mem[16'h0009] = 8'h01;
        mem[16'h0100] = op_halt;
        mem[16'h0101] = op_stop;
        mem[16'h0102] = op_ei;
        mem[16'h0103] = op_nop;
        for (int i = 0; i < num_int; i++) begin  // DI then HALT at every vector
            mem[16'h0040 + 8 * i]     = op_di;
            mem[16'h0040 + 8 * i + 1] = op_halt;
        end
    endtask

    // Next rd rise, its address and its distance from the last one
    task automatic expect_rd(input addr_t exp_addr, input int exp_gap);
        logic prev;
        do begin
            prev = rd;
            @(negedge clk);
        end while (!(rd && !prev));
        assert (addr == exp_addr)
        else begin
            errors++;
            $display("Error: addr %h, expected %h", addr, exp_addr);
        end
        if (exp_gap != 0) begin
            assert (cycle - last_rd == exp_gap)
            else begin
                errors++;
                $display("rd came %0d clocks after the previous one instead of %0d",
                         cycle - last_rd, exp_gap);
            end
        end
        last_rd = cycle;
    endtask

    task automatic check_write(input addr_t exp_addr, input data_t exp_data);
        while (!wr)
            @(negedge clk);
        assert (addr == exp_addr && dout == exp_data)
        else begin
            errors++;
            $display("Error: addr %h dout %h, expected %h %h", addr, dout, exp_addr, exp_data);
        end
    endtask

    task automatic wait_done();
        while (!done)
            @(negedge clk);
    endtask

    function automatic addr_t vector_for(input int_mask_t lines);
        int idx;
        idx = 0;
        while (!lines[idx])
            idx++;
        return 16'h0040 + 16'(8 * idx);
    endfunction

    // One-hot of the highest priority line
    function automatic int_mask_t lowest_line(input int_mask_t lines);
        int_mask_t one_hot;
        int        idx;
        one_hot = '0;
        idx     = 0;
        while (!lines[idx])
            idx++;
        one_hot[idx] = 1'b1;
        return one_hot;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        int_en       = '0;
        int_flags_in = '0;
        key_in       = '0;
        load_program();
        wait (rst == 1'b0);
        assert (!rd && !wr && !done)
        else begin
            errors++;
            $display("Error: rd %h wr %h done %h after reset", rd, wr, done);
        end
        expect_rd(16'h0000, 0);
        expect_rd(16'h0001, 4);
        expect_rd(16'h0002, 4);
        expect_rd(16'h0003, 4);  // LD A,n
        expect_rd(16'h0004, 4);
        expect_rd(16'h0005, 4);  // LDH (n),A
        expect_rd(16'h0006, 4);
        check_write(16'hff42, 8'h5a);
        expect_rd(16'h0007, 8);  // JP nn
        expect_rd(16'h0008, 4);
        expect_rd(16'h0009, 4);
        expect_rd(16'h0100, 8);  // HALT

        wait_done();
        repeat (12) @(negedge clk);
        int_en       = 5'b00100;
        int_flags_in = 5'b00100;  // IME still off
        expect_rd(16'h0101, 0);   // STOP
        int_flags_in = '0;

        wait_done();
        repeat (12) @(negedge clk);
        key_in = 8'h80;
        expect_rd(16'h0102, 0);  // EI
        key_in = '0;
        expect_rd(16'h0103, 4);

        do
            flags = int_mask_t'($random(seed));
        while (flags == '0);
        int_en       = '1;
        int_flags_in = flags;
        vec          = vector_for(flags);
        expect_rd(vec, 8);  // One idle cycle, then the vector
        assert (drop_seen == lowest_line(flags))
        else begin
            errors++;
            $display("Error: int_flags_out dropped %h, expected %h", drop_seen,
                     lowest_line(flags));
        end
        int_flags_in = '0;
        expect_rd(vec + 16'd1, 4);
        wait_done();
        repeat (8) @(negedge clk);

        assert (mem[16'hff42] == 8'h5a)
        else begin
            errors++;
            $display("Error: mem[ff42] %h, expected 5a", mem[16'hff42]);
        end
        $display("Errors: %0d testbench checks, %0d assertions", errors,
                 i_dut.i_assertions.fail_count);
        if (errors == 0 && i_dut.i_assertions.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: program did not reach its last HALT within %0d ns", watchdog_ns);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* tests/cpu_assertions.sv */
`timescale 1ns/100ps

module cpu_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   phi,
    input cpu_bus_pkg::addr_t     addr,
    input logic                   rd,
    input logic                   wr,
    input logic                   done,
    input cpu_isa_pkg::int_mask_t int_en,
    input cpu_isa_pkg::int_mask_t int_flags_in,
    input cpu_isa_pkg::int_mask_t int_flags_out
);
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    int        fail_count = 0;
    int_mask_t pend;
    int_mask_t lowest;
    int_mask_t dropped;
    addr_t     vec_q;

    assign pend    = int_flags_in & int_en;
    assign lowest  = pend & (~pend + 5'd1);  // Lowest set bit only
    assign dropped = int_flags_in ^ int_flags_out;

    // Vector of the serviced line, 0040 + 8 * index
    always @(posedge clk) begin
        if (dropped != '0) begin
            vec_q <= 16'h0040;
            for (int i = 0; i < num_int; i++) begin
                if (dropped[i])
                    vec_q <= 16'h0040 + 16'(8 * i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bus protocol
    //////////////////////////////////////////////////////////////////////
    reset_quiet: assert property (@(posedge clk) rst |-> !rd && !wr && !done)
    else begin
        fail_count++;
        $error("Error: rd %h wr %h done %h in reset", $sampled(rd), $sampled(wr),
               $sampled(done));
    end

    rd_in_t1: assert property (@(posedge clk) disable iff (rst) $rose(rd) |-> phi && !wr)
    else begin
        fail_count++;
        $error("Error: phi %h wr %h at rd rise", $sampled(phi), $sampled(wr));
    end

    // High through T1 and T2, low again in T3
    rd_two_clocks: assert property (@(posedge clk) disable iff (rst)
        $rose(rd) |=> rd ##1 !rd)
    else begin
        fail_count++;
        $error("Error: rd pulse has the wrong length");
    end

    wr_high_page: assert property (@(posedge clk) disable iff (rst)
        wr |-> addr[15:8] == 8'hff && !phi && !rd)
    else begin
        fail_count++;
        $error("Error: addr %h phi %h during wr", $sampled(addr), $sampled(phi));
    end

    wr_one_clock: assert property (@(posedge clk) disable iff (rst) wr |=> !wr)
    else begin
        fail_count++;
        $error("Error: wr stayed high for more than one clock");
    end

    halted_quiet: assert property (@(posedge clk) disable iff (rst) done |-> !rd && !wr)
    else begin
        fail_count++;
        $error("Error: rd %h wr %h while done", $sampled(rd), $sampled(wr));
    end

    //////////////////////////////////////////////////////////////////////
    // Interrupt dispatch
    //////////////////////////////////////////////////////////////////////
    flag_drop: assert property (@(posedge clk) disable iff (rst)
        dropped != '0 |-> dropped == lowest)
    else begin
        fail_count++;
        $error("Error: int_flags_out %h, expected %h", $sampled(int_flags_out),
               $sampled(int_flags_in & ~lowest));
    end

    vector_fetch: assert property (@(posedge clk) disable iff (rst)
        $rose(rd) && $past(dropped != '0, 2) |-> addr == vec_q)
    else begin
        fail_count++;
        $error("Error: addr %h at vector fetch, expected %h", $sampled(addr), vec_q);
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter int half_period  = 4,   // 8 ns clock
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Released on a falling edge like every other input
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* design/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   phi,
    output cpu_bus_pkg::addr_t     addr,
    output cpu_bus_pkg::data_t     dout,
    input  cpu_bus_pkg::data_t     din,
    output logic                   rd,
    output logic                   wr,
    input  cpu_isa_pkg::int_mask_t int_en,
    input  cpu_isa_pkg::int_mask_t int_flags_in,
    output cpu_isa_pkg::int_mask_t int_flags_out,
    input  cpu_bus_pkg::data_t     key_in,
    output logic                   done
);
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    t_state_e t_state;
    m_cycle_t m_cycle;
    bus_op_e  bus_op;
    ab_src_e  ab_src;
    db_src_e  db_src;
    data_t    opcode;
    data_t    wdata;
    addr_t    imm;
    addr_t    bus_addr;
    addr_t    int_vector;
    logic     pc_inc;
    logic     pc_load;
    logic     acc_load;
    logic     ime_set;
    logic     ime_clr;
    logic     halt;
    logic     stop;
    logic     int_dispatch;
    logic     wake;

    bus_unit i_bus_unit (
        .clk      (clk),
        .rst      (rst),
        .bus_op   (bus_op),
        .m_cycle  (m_cycle),
        .bus_addr (bus_addr),
        .wdata    (wdata),
        .din      (din),
        .t_state  (t_state),
        .opcode   (opcode),
        .imm      (imm),
        .addr     (addr),
        .dout     (dout),
        .rd       (rd),
        .wr       (wr),
        .phi      (phi)
    );

    control i_control (
        .clk          (clk),
        .rst          (rst),
        .t_state      (t_state),
        .opcode       (opcode),
        .int_dispatch (int_dispatch),
        .wake         (wake),
        .m_cycle      (m_cycle),
        .bus_op       (bus_op),
        .ab_src       (ab_src),
        .db_src       (db_src),
        .pc_inc       (pc_inc),
        .pc_load      (pc_load),
        .acc_load     (acc_load),
        .ime_set      (ime_set),
        .ime_clr      (ime_clr),
        .halt         (halt),
        .stop         (stop),
        .done         (done)
    );

    datapath i_datapath (
        .clk          (clk),
        .rst          (rst),
        .t_state      (t_state),
        .pc_inc       (pc_inc),
        .pc_load      (pc_load),
        .acc_load     (acc_load),
        .int_dispatch (int_dispatch),
        .int_vector   (int_vector),
        .imm          (imm),
        .ab_src       (ab_src),
        .db_src       (db_src),
        .bus_addr     (bus_addr),
        .wdata        (wdata)
    );

    interrupt_unit i_interrupt_unit (
        .clk           (clk),
        .rst           (rst),
        .t_state       (t_state),
        .bus_op        (bus_op),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .ime_set       (ime_set),
        .ime_clr       (ime_clr),
        .halt          (halt),
        .stop          (stop),
        .key_in        (key_in),
        .int_dispatch  (int_dispatch),
        .int_vector    (int_vector),
        .int_flags_out (int_flags_out),
        .wake          (wake)
    );

endmodule

/* design/interrupt_unit.sv */
`timescale 1ns/100ps

module interrupt_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_bus_pkg::t_state_e  t_state,
    input  cpu_bus_pkg::bus_op_e   bus_op,
    input  cpu_isa_pkg::int_mask_t int_en,
    input  cpu_isa_pkg::int_mask_t int_flags_in,
    input  logic                   ime_set,
    input  logic                   ime_clr,
    input  logic                   halt,
    input  logic                   stop,
    input  cpu_bus_pkg::data_t     key_in,
    output logic                   int_dispatch,
    output cpu_bus_pkg::addr_t     int_vector,
    output cpu_isa_pkg::int_mask_t int_flags_out,
    output logic                   wake
);
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    logic      ime;
    int_mask_t pending;
    int_mask_t win_onehot;
    int_mask_t win_q;  // Bit being serviced
    addr_t     win_vec;
    logic      dispatch_set;
    logic      dispatch_end;
    logic      wake_next;

    assign pending = int_flags_in & int_en & {num_int{ime}};

    // Lowest index has priority
    always_comb begin
        win_onehot = '0;
        win_vec    = int_vector_base;
        for (int i = num_int - 1; i >= 0; i--) begin
            if (pending[i]) begin
                win_onehot    = '0;
                win_onehot[i] = 1'b1;
                win_vec       = int_vector_base + addr_t'(i) * addr_t'(int_vector_step);
            end
        end
    end

    assign dispatch_set = (t_state == T2) && (bus_op == FETCH) && (pending != '0)
                          && !int_dispatch;
    assign dispatch_end = int_dispatch && (t_state == T3) && (bus_op == IDLE);

    ///////////////////////////////////////////////////////////////////////
    // IME and dispatch flag
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ime          <= 1'b0;
            int_dispatch <= 1'b0;
        end else begin
            if (ime_clr || dispatch_set)
                ime <= 1'b0;
            else if (ime_set)
                ime <= 1'b1;  // No one-instruction delay
            if (dispatch_set)
                int_dispatch <= 1'b1;
            else if (dispatch_end)
                int_dispatch <= 1'b0;
        end
    end

    // Winner held until the idle cycle loads PC
    always_ff @(posedge clk) begin
        if (dispatch_set) begin
            win_q      <= win_onehot;
            int_vector <= win_vec;
        end
    end

    assign int_flags_out = dispatch_end ? (int_flags_in & ~win_q) : int_flags_in;

    // IME plays no part in waking
    assign wake_next = (halt && (int_flags_in & int_en) != '0)
                       || (stop && ((int_flags_in & int_en) != '0 || key_in != '0));

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wake <= 1'b0;
        else
            wake <= wake_next;
    end

endmodule

/* design/datapath.sv */
`timescale 1ns/100ps

module datapath (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_bus_pkg::t_state_e t_state,
    input  logic                  pc_inc,
    input  logic                  pc_load,
    input  logic                  acc_load,
    input  logic                  int_dispatch,
    input  cpu_bus_pkg::addr_t    int_vector,
    input  cpu_bus_pkg::addr_t    imm,
    input  cpu_bus_pkg::ab_src_e  ab_src,
    input  cpu_bus_pkg::db_src_e  db_src,
    output cpu_bus_pkg::addr_t    bus_addr,
    output cpu_bus_pkg::data_t    wdata
);
    import cpu_bus_pkg::*;

    addr_t pc;
    data_t acc;

    // Program counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pc <= '0;
        else if (pc_inc && t_state == T1)
            pc <= pc + 16'd1;  // After the address is latched at T0
        else if (pc_load && t_state == T3)
            pc <= int_dispatch ? int_vector : imm;
    end

    always_ff @(posedge clk) begin
        if (acc_load && t_state == T3)
            acc <= imm[7:0];
    end

    ///////////////////////////////////////////////////////////////////////
    // Bus source selection
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        case (ab_src)
            PC:            bus_addr = pc;
            IMM:           bus_addr = imm;
            IMM_HIGH_PAGE: bus_addr = {high_page, imm[7:0]};  // LDH page
            default:       bus_addr = pc;
        endcase
    end

    assign wdata = (db_src == ACC) ? acc : imm[7:0];

endmodule

/* control/control.sv */
`timescale 1ns/100ps

module control (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_bus_pkg::t_state_e t_state,
    input  cpu_bus_pkg::data_t    opcode,
    input  logic                  int_dispatch,
    input  logic                  wake,
    output cpu_isa_pkg::m_cycle_t m_cycle,
    output cpu_bus_pkg::bus_op_e  bus_op,
    output cpu_bus_pkg::ab_src_e  ab_src,
    output cpu_bus_pkg::db_src_e  db_src,
    output logic                  pc_inc,
    output logic                  pc_load,
    output logic                  acc_load,
    output logic                  ime_set,
    output logic                  ime_clr,
    output logic                  halt,
    output logic                  stop,
    output logic                  done
);
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    logic next;
    logic inc_req;
    logic load_req;
    logic acc_req;
    logic set_req;
    logic clr_req;
    logic halt_req;
    logic stop_req;

    ///////////////////////////////////////////////////////////////////////
    // Decode per M-cycle
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        bus_op   = IDLE;
        ab_src   = PC;
        db_src   = ACC;
        next     = 1'b0;
        inc_req  = 1'b0;
        load_req = 1'b0;
        acc_req  = 1'b0;
        set_req  = 1'b0;
        clr_req  = 1'b0;
        halt_req = 1'b0;
        stop_req = 1'b0;
        if (m_cycle == 3'd0) begin
            if (!halt && !stop) begin
                bus_op  = FETCH;
                inc_req = 1'b1;
                // Opcode is only valid from T3 on
                if (int_dispatch)
                    next = 1'b1;  // Fetched byte is dropped
                else begin
                    case (opcode)
                        op_ld_a_n, op_ldh_n_a, op_jp_nn: next = 1'b1;
                        op_di:   clr_req  = 1'b1;
                        op_ei:   set_req  = 1'b1;
                        op_halt: halt_req = 1'b1;
                        op_stop: stop_req = 1'b1;
                        default: ;  // NOP and unknown opcodes
                    endcase
                end
            end
        end else if (int_dispatch) begin
            load_req = 1'b1;  // Idle cycle, PC takes the vector
        end else begin
            case (opcode)
                op_ld_a_n: begin
                    bus_op  = READ;
                    inc_req = 1'b1;
                    acc_req = 1'b1;
                end
                op_ldh_n_a: begin
                    if (m_cycle == 3'd1) begin
                        bus_op  = READ;
                        inc_req = 1'b1;
                        next    = 1'b1;
                    end else begin
                        bus_op = WRITE;
                        ab_src = IMM_HIGH_PAGE;
                    end
                end
                op_jp_nn: begin
                    if (m_cycle != 3'd3) begin  // Low then high byte
                        bus_op  = READ;
                        inc_req = 1'b1;
                        next    = 1'b1;
                    end else
                        load_req = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Strobes act only in their own T-state
    assign pc_inc   = inc_req  && (t_state == T1);
    assign pc_load  = load_req && (t_state == T3);
    assign acc_load = acc_req  && (t_state == T3);
    assign ime_set  = set_req  && (t_state == T3);
    assign ime_clr  = clr_req  && (t_state == T3);

    ///////////////////////////////////////////////////////////////////////
    // M-cycle counter and low power state
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_cycle <= '0;
            halt    <= 1'b0;
            stop    <= 1'b0;
        end else if (t_state == T3) begin
            m_cycle <= next ? m_cycle + 3'd1 : 3'd0;
            if (halt || stop) begin
                if (wake) begin  // Resume fetch at the next PC
                    halt <= 1'b0;
                    stop <= 1'b0;
                end
            end else begin
                halt <= halt_req;
                stop <= stop_req;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            done <= 1'b0;
        else
            done <= halt | stop;
    end

endmodule

/* design/bus_unit.sv */
`timescale 1ns/100ps

module bus_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_bus_pkg::bus_op_e  bus_op,
    input  cpu_isa_pkg::m_cycle_t m_cycle,
    input  cpu_bus_pkg::addr_t    bus_addr,
    input  cpu_bus_pkg::data_t    wdata,
    input  cpu_bus_pkg::data_t    din,
    output cpu_bus_pkg::t_state_e t_state,
    output cpu_bus_pkg::data_t    opcode,
    output cpu_bus_pkg::addr_t    imm,
    output cpu_bus_pkg::addr_t    addr,
    output cpu_bus_pkg::data_t    dout,
    output logic                  rd,
    output logic                  wr,
    output logic                  phi
);
    import cpu_bus_pkg::*;

    // Free-running T-state counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            t_state <= T0;
        else
            t_state <= t_state_e'(t_state + 2'd1);
    end

    ///////////////////////////////////////////////////////////////////////
    // Bus cycle driver
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr   <= '0;
            dout   <= '0;
            rd     <= 1'b0;
            wr     <= 1'b0;
            phi    <= 1'b1;
            opcode <= '0;  // Decodes as NOP
        end else begin
            case (t_state)
                T0: begin
                    addr <= bus_addr;
                    rd   <= (bus_op == FETCH) || (bus_op == READ);
                end
                T1: begin
                    phi <= 1'b0;  // Low through T2 and T3
                end
                T2: begin
                    if (bus_op == FETCH)
                        opcode <= din;
                    if (bus_op == WRITE) begin
                        wr   <= 1'b1;
                        dout <= wdata;
                    end
                    rd <= 1'b0;
                end
                T3: begin
                    wr   <= 1'b0;
                    dout <= '0;
                    phi  <= 1'b1;  // High again for next T0
                end
            endcase
        end
    end

    // Immediate bytes of the current instruction
    always_ff @(posedge clk) begin
        if (t_state == T2 && bus_op == READ) begin
            if (m_cycle == 3'd1)
                imm[7:0] <= din;
            else if (m_cycle == 3'd2)
                imm[15:8] <= din;
        end
    end

endmodule

/* common/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    localparam int num_int = 5;  // VBlank, LCD, timer, serial, joypad

    typedef logic [2:0]         m_cycle_t;
    typedef logic [num_int-1:0] int_mask_t;

    ///////////////////////////////////////////////////////////////////////
    // Opcodes kept by this core
    ///////////////////////////////////////////////////////////////////////
    localparam logic [7:0] op_nop     = 8'h00;
    localparam logic [7:0] op_ld_a_n  = 8'h3e;
    localparam logic [7:0] op_ldh_n_a = 8'he0;
    localparam logic [7:0] op_jp_nn   = 8'hc3;
    localparam logic [7:0] op_di      = 8'hf3;
    localparam logic [7:0] op_ei      = 8'hfb;
    localparam logic [7:0] op_halt    = 8'h76;
    localparam logic [7:0] op_stop    = 8'h10;

    // Vector table, 0040 for bit 0 up to 0060 for bit 4
    localparam logic [15:0] int_vector_base = 16'h0040;
    localparam logic [7:0]  int_vector_step = 8'h08;

endpackage

/* common/cpu_bus_pkg.sv */
package cpu_bus_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Bus widths
    ///////////////////////////////////////////////////////////////////////
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // Four clocks per machine cycle
    typedef enum logic [1:0] {
        T0 = 2'd0,  // Address setup
        T1 = 2'd1,
        T2 = 2'd2,  // Data sample or drive
        T3 = 2'd3   // Bus idle
    } t_state_e;

    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        FETCH = 2'b01,
        WRITE = 2'b10,
        READ  = 2'b11
    } bus_op_e;

    typedef enum logic [1:0] {
        PC            = 2'd0,
        IMM           = 2'd1,
        IMM_HIGH_PAGE = 2'd2  // FF00 + low immediate byte
    } ab_src_e;

    typedef enum logic {
        ACC     = 1'b0,
        IMM_LOW = 1'b1
    } db_src_e;

    localparam data_t high_page = 8'hff;

endpackage
